// ==== sram_test_top.f ====
logic/sram_test_pkg.sv
logic/test_config.sv
logic/addr_iter.sv
logic/pattern_gen.sv
logic/expect_fifo.sv
logic/sram_ctrl.sv
logic/sram_tester.sv
logic/sram_test_top.sv
testbench/sram_model.sv
testbench/sram_test_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the SRAM BIST testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sram_test_sim
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sram_test_tb \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
  -f sram_test_top.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test completed successfully" "$SIM_LOG"; then
  exit 0
fi
exit 1

// ==== testbench/sram_tests.txt ====
# columns in hex: last_addr seed fault_addr fault_mask expect_pass
# expect_pass is 1 when the sweep should finish with no mismatch
01f 1234 000 0000 1
03f a5a5 010 0001 0
03f 0000 040 ffff 1
03f 00ff 020 0000 1
07f 5a5a 07f 8000 0
07f c3c3 000 0000 1
000 beef 000 0100 0
0ff 0f0f 0a5 0040 0
0ff 7e81 100 0001 1
3ff 4321 3ff 0002 0
3ff 9999 000 0000 1

// ==== testbench/sram_test_tb.sv ====
`timescale 1ns/1ps

module sram_test_tb;

  import sram_test_pkg::*;

  localparam int FIFO_DEPTH_LOG2 = 2;
  localparam int ACCESS_CYCLES   = 2;
  // generous bound on clocks spent per SRAM access
  localparam int CYCLES_PER_ACCESS = 4 * (ACCESS_CYCLES + 3);
  localparam int HALT_WINDOW       = 200;
  localparam string TEST_FILE      = "testbench/sram_tests.txt";

  logic         clk;
  logic         reset;
  logic         cfg_load;
  test_cfg_t    cfg_in;
  test_status_t status;
  sram_pins_t   pins;
  wire sram_data_t sram_dq;
  sram_addr_t   fault_addr;
  sram_data_t   fault_mask;

  int         errors;
  int         tests_run;
  int         fd;
  int         fields;
  int         got;
  int         line_no;
  string      line;
  sram_addr_t t_last;
  sram_data_t t_seed;
  sram_addr_t t_fault_addr;
  sram_data_t t_fault_mask;
  logic       t_expect_pass;
  logic       expect_detect;

  sram_test_top #(
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
    .ACCESS_CYCLES  (ACCESS_CYCLES)
  ) UUT (
    .clk     (clk),
    .reset   (reset),
    .cfg_load(cfg_load),
    .cfg_in  (cfg_in),
    .status  (status),
    .pins    (pins),
    .sram_dq (sram_dq)
  );

  sram_model u_sram_model (
    .pins      (pins),
    .fault_addr(fault_addr),
    .fault_mask(fault_mask),
    .sram_dq   (sram_dq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task report_mismatch(input string name, input int unsigned expected,
                       input int unsigned actual);
    $display("mismatch at time %0t: %s expected %0h actual %0h",
             $time, name, expected, actual);
    errors++;
  endtask

  task report_failure(input string what);
    $display("error at time %0t: %s", $time, what);
    errors++;
  endtask

  // config and fault change together, tester restarts two edges later
  task load_test();
    cfg_in     = '{last_addr: t_last, seed: t_seed};
    cfg_load   = 1'b1;
    fault_addr = t_fault_addr;
    fault_mask = t_fault_mask;
    @(posedge clk);
    #2;
    cfg_load = 1'b0;
    @(posedge clk);
    #2;
    if (status.pass !== 1'b1) report_mismatch("status.pass", 1, status.pass);
    if (status.done !== 1'b0) report_mismatch("status.done", 0, status.done);
  endtask

  task wait_for_outcome(input int limit, output logic saw_done, output logic saw_fail);
    int cycles;
    cycles   = 0;
    saw_done = 1'b0;
    saw_fail = 1'b0;
    while (!saw_done && !saw_fail && cycles < limit) begin
      @(posedge clk);
      #2;
      cycles++;
      if (!status.pass) saw_fail = 1'b1;
      else if (status.done) saw_done = 1'b1;
    end
  endtask

  // tester must sit in HALT with frozen failure fields
  task observe_halt();
    int         cycles;
    logic       stable;
    sram_addr_t held_addr;
    pattern_t   held_pattern;
    cycles       = 0;
    stable       = 1'b1;
    held_addr    = status.fail_addr;
    held_pattern = status.fail_pattern;
    while (stable && cycles < HALT_WINDOW) begin
      @(posedge clk);
      #2;
      cycles++;
      if (status.done !== 1'b0) begin
        report_mismatch("status.done", 0, status.done);
        stable = 1'b0;
      end
      if (status.pass !== 1'b0) begin
        report_mismatch("status.pass", 0, status.pass);
        stable = 1'b0;
      end
      if (status.fail_addr !== held_addr) begin
        report_mismatch("status.fail_addr", held_addr, status.fail_addr);
        stable = 1'b0;
      end
      if (status.fail_pattern !== held_pattern) begin
        report_mismatch("status.fail_pattern", held_pattern, status.fail_pattern);
        stable = 1'b0;
      end
    end
  endtask

  task run_test();
    logic saw_done;
    logic saw_fail;
    int   limit;
    // a fault shows only when it flips bits inside the swept range
    expect_detect = (t_fault_mask != '0) && (t_fault_addr <= t_last);
    if (t_expect_pass !== !expect_detect) begin
      report_failure($sformatf("line %0d of the test file disagrees with the fault rule",
                               line_no));
    end
    limit = 5 * 2 * (int'(t_last) + 1) * CYCLES_PER_ACCESS + 100;
    tests_run++;
    load_test();
    wait_for_outcome(limit, saw_done, saw_fail);
    if (!saw_done && !saw_fail) begin
      report_failure($sformatf("timed out after %0d cycles on test line %0d",
                               limit, line_no));
    end else if (expect_detect) begin
      if (saw_done) begin
        report_mismatch("status.done", 0, 1);
      end else begin
        if (status.fail_addr !== t_fault_addr) begin
          report_mismatch("status.fail_addr", t_fault_addr, status.fail_addr);
        end
        if (status.fail_pattern !== PAT_ZEROS) begin
          report_mismatch("status.fail_pattern", PAT_ZEROS, status.fail_pattern);
        end
        observe_halt();
      end
    end else begin
      if (saw_fail) report_mismatch("status.pass", 1, 0);
    end
  endtask

  initial begin
    reset      = 1'b1;
    cfg_load   = 1'b0;
    cfg_in     = '0;
    fault_addr = '0;
    fault_mask = '0;
    errors     = 0;
    tests_run  = 0;
    line_no    = 0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    // idle status before the first load
    repeat (3) begin
      @(posedge clk);
      #2;
      if (status.pass !== 1'b1) report_mismatch("status.pass", 1, status.pass);
      if (status.done !== 1'b0) report_mismatch("status.done", 0, status.done);
    end

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      report_failure({"could not open ", TEST_FILE});
    end else begin
      while (!$feof(fd)) begin
        line = "";
        got  = $fgets(line, fd);
        line_no++;
        if (got > 0 && line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h", t_last, t_seed, t_fault_addr,
                           t_fault_mask, t_expect_pass);
          if (fields != 5) begin
            report_failure($sformatf("line %0d of the test file is malformed", line_no));
          end else begin
            run_test();
          end
        end
      end
      $fclose(fd);
    end
    if (tests_run == 0) report_failure("no test was read from the test file");

    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== testbench/sram_model.sv ====
`timescale 1ns/1ps

module sram_model (
  input  sram_test_pkg::sram_pins_t pins,
  input  sram_test_pkg::sram_addr_t fault_addr,
  input  sram_test_pkg::sram_data_t fault_mask,
  inout  wire sram_test_pkg::sram_data_t sram_dq
);

  import sram_test_pkg::*;

  localparam int WORDS = 2 ** ADDR_BITS;
  // data is taken this long into the write strobe
  localparam int SETUP_NS = 5;

  sram_data_t mem [WORDS];
  sram_data_t rd_word;
  logic       read_en;

  always @(negedge pins.we_n) begin
    #(SETUP_NS);
    if (!pins.ce_n && !pins.we_n) begin
      mem[pins.addr] = sram_dq;
    end
  end

  // one stuck location, seen on reads only
  assign rd_word = (pins.addr == fault_addr) ? (mem[pins.addr] ^ fault_mask)
                                             : mem[pins.addr];
  assign read_en = !pins.ce_n && !pins.oe_n;
  assign sram_dq = read_en ? rd_word : 'z;

endmodule

// ==== logic/sram_test_top.sv ====
`timescale 1ns/1ps

module sram_test_top #(
  parameter int FIFO_DEPTH_LOG2 = 2,
  parameter int ACCESS_CYCLES   = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cfg_load,
  input  sram_test_pkg::test_cfg_t    cfg_in,
  output sram_test_pkg::test_status_t status,
  output sram_test_pkg::sram_pins_t   pins,
  inout  wire sram_test_pkg::sram_data_t sram_dq
);

  import sram_test_pkg::*;

  test_cfg_t  cfg;
  logic       restart;
  wr_req_t    wr_req;
  logic       wr_valid;
  logic       wr_ready;
  logic       bvalid;
  sram_addr_t rd_addr;
  logic       rd_valid;
  logic       rd_ready;
  sram_data_t rdata;
  logic       rvalid;

  test_config u_test_config (
    .clk     (clk),
    .reset   (reset),
    .cfg_load(cfg_load),
    .cfg_in  (cfg_in),
    .cfg     (cfg),
    .restart (restart)
  );

  sram_tester #(
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) u_sram_tester (
    .clk     (clk),
    .reset   (reset),
    .restart (restart),
    .cfg     (cfg),
    .wr_req  (wr_req),
    .wr_valid(wr_valid),
    .wr_ready(wr_ready),
    .bvalid  (bvalid),
    .rd_addr (rd_addr),
    .rd_valid(rd_valid),
    .rd_ready(rd_ready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .status  (status)
  );

  sram_ctrl #(
    .ACCESS_CYCLES(ACCESS_CYCLES)
  ) u_sram_ctrl (
    .clk     (clk),
    .reset   (reset),
    .wr_req  (wr_req),
    .wr_valid(wr_valid),
    .wr_ready(wr_ready),
    .bvalid  (bvalid),
    .rd_addr (rd_addr),
    .rd_valid(rd_valid),
    .rd_ready(rd_ready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .pins    (pins),
    .sram_dq (sram_dq)
  );

endmodule

// ==== logic/sram_tester.sv ====
`timescale 1ns/1ps

module sram_tester #(
  parameter int FIFO_DEPTH_LOG2 = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        restart,
  input  sram_test_pkg::test_cfg_t    cfg,
  output sram_test_pkg::wr_req_t      wr_req,
  output logic                        wr_valid,
  input  logic                        wr_ready,
  input  logic                        bvalid,
  output sram_test_pkg::sram_addr_t   rd_addr,
  output logic                        rd_valid,
  input  logic                        rd_ready,
  input  sram_test_pkg::sram_data_t   rdata,
  input  logic                        rvalid,
  output sram_test_pkg::test_status_t status
);

  import sram_test_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WAIT_B,
    READ,
    DRAIN,
    NEXT,
    HALT
  } tester_state_t;

  tester_state_t state;
  tester_state_t state_next;

  logic       init;
  logic       addr_clear;
  logic       addr_inc;
  logic       addr_last;
  sram_addr_t cur_addr;
  sram_addr_t resp_addr;
  logic       resp_last;
  logic       pat_clear;
  logic       pat_next;
  pattern_t   cur_pattern;
  sram_data_t pat_data;
  logic       final_pat;
  logic       rd_fire;
  logic       pop;
  sram_data_t exp_data;
  logic       fifo_empty;
  logic       fifo_almost_full;
  logic       mismatch;

  // a restart behaves exactly like a reset
  assign init = reset | restart;

  assign addr_clear = (state == IDLE);
  assign rd_fire    = rd_valid && rd_ready;
  assign addr_inc   = (state == WAIT_B && bvalid) || rd_fire;
  assign pat_clear  = (state == IDLE) || (state == NEXT && final_pat);
  assign pat_next   = (state == NEXT) && !final_pat;

  // responses seen in IDLE belong to a request from before a restart
  assign pop      = rvalid && (state == READ || state == DRAIN);
  assign mismatch = pop && (rdata != exp_data);

  addr_iter u_addr_iter (
    .clk      (clk),
    .reset    (init),
    .clear    (addr_clear),
    .inc      (addr_inc),
    .last_addr(cfg.last_addr),
    .addr     (cur_addr),
    .last     (addr_last)
  );

  // follows the read responses, gives the failing address
  addr_iter u_resp_iter (
    .clk      (clk),
    .reset    (init),
    .clear    (addr_clear),
    .inc      (pop),
    .last_addr(cfg.last_addr),
    .addr     (resp_addr),
    .last     (resp_last)
  );

  pattern_gen u_pattern_gen (
    .clk      (clk),
    .reset    (init),
    .clear    (pat_clear),
    .next     (pat_next),
    .seed     (cfg.seed),
    .addr     (cur_addr),
    .pattern  (cur_pattern),
    .data     (pat_data),
    .final_pat(final_pat)
  );

  expect_fifo #(
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) u_expect_fifo (
    .clk        (clk),
    .reset      (init),
    .push       (rd_fire),
    .push_data  (pat_data),
    .pop        (pop),
    .pop_data   (exp_data),
    .empty      (fifo_empty),
    .almost_full(fifo_almost_full)
  );

  assign wr_req   = '{addr: cur_addr, data: pat_data};
  assign wr_valid = (state == WRITE);
  assign rd_addr  = cur_addr;
  assign rd_valid = (state == READ) && !fifo_almost_full;

  always_comb begin
    state_next = state;
    case (state)
      // wait for the controller to finish anything left over
      IDLE:   if (wr_ready) state_next = WRITE;
      WRITE:  if (wr_ready) state_next = WAIT_B;
      WAIT_B: if (bvalid) state_next = addr_last ? READ : WRITE;
      READ: begin
        if (mismatch) begin
          state_next = HALT;
        end else if (rd_fire && addr_last) begin
          state_next = DRAIN;
        end
      end
      DRAIN: begin
        if (mismatch) begin
          state_next = HALT;
        end else if (fifo_empty) begin
          state_next = NEXT;
        end
      end
      NEXT:    state_next = WRITE;
      default: state_next = HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (init) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (init) begin
      status.done         <= 1'b0;
      status.pass         <= 1'b1;
      status.fail_addr    <= '0;
      status.fail_pattern <= PAT_ZEROS;
    end else begin
      status.done <= (state == NEXT) && final_pat;
      if (mismatch) begin
        status.pass         <= 1'b0;
        status.fail_addr    <= resp_addr;
        status.fail_pattern <= cur_pattern;
      end
    end
  end

  // the sweep wraps exactly when the last response comes back
  assert property (@(posedge clk) disable iff (init)
    (state == DRAIN && pop) |-> resp_last)
    else $error("sram_tester: response count out of step with requests");

  assert property (@(posedge clk) disable iff (reset)
    (rvalid && state != IDLE) |-> !fifo_empty)
    else $error("sram_tester: read response with no expected word");

endmodule

// ==== logic/sram_ctrl.sv ====
`timescale 1ns/1ps

module sram_ctrl #(
  parameter int ACCESS_CYCLES = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  sram_test_pkg::wr_req_t    wr_req,
  input  logic                      wr_valid,
  output logic                      wr_ready,
  output logic                      bvalid,
  input  sram_test_pkg::sram_addr_t rd_addr,
  input  logic                      rd_valid,
  output logic                      rd_ready,
  output sram_test_pkg::sram_data_t rdata,
  output logic                      rvalid,
  output sram_test_pkg::sram_pins_t pins,
  inout  wire sram_test_pkg::sram_data_t sram_dq
);

  import sram_test_pkg::*;

  localparam int CNT_BITS = $clog2(ACCESS_CYCLES + 1);
  localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(ACCESS_CYCLES - 1);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    RESP
  } ctrl_state_t;

  ctrl_state_t         state;
  logic [CNT_BITS-1:0] strobe_cnt;
  logic                is_write;
  sram_addr_t          addr_q;
  sram_data_t          wdata_q;
  logic                strobe_end;

  // one request at a time, write wins a tie
  assign wr_ready   = (state == IDLE);
  assign rd_ready   = (state == IDLE) && !wr_valid;
  assign strobe_end = (strobe_cnt == CNT_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      strobe_cnt <= '0;
      is_write   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          strobe_cnt <= '0;
          if (wr_valid) begin
            state    <= WRITE;
            is_write <= 1'b1;
          end else if (rd_valid) begin
            state    <= READ;
            is_write <= 1'b0;
          end
        end
        WRITE, READ: begin
          if (strobe_end) begin
            state <= RESP;
          end else begin
            strobe_cnt <= strobe_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // request payload and read capture
  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      if (wr_valid) begin
        addr_q  <= wr_req.addr;
        wdata_q <= wr_req.data;
      end else if (rd_valid) begin
        addr_q <= rd_addr;
      end
    end
    // sample on the last cycle of the read strobe
    if (state == READ && strobe_end) begin
      rdata <= sram_dq;
    end
  end

  assign bvalid = (state == RESP) && is_write;
  assign rvalid = (state == RESP) && !is_write;

  assign pins = '{
    addr: addr_q,
    we_n: (state != WRITE),
    oe_n: (state != READ),
    ce_n: !(state == WRITE || state == READ)
  };

  assign sram_dq = (state == WRITE) ? wdata_q : 'z;

  // the SRAM and this driver must never fight over the data bus
  assert property (@(posedge clk) disable iff (reset) !(!pins.we_n && !pins.oe_n))
    else $error("sram_ctrl: we_n and oe_n low together");

endmodule

// ==== logic/expect_fifo.sv ====
`timescale 1ns/1ps

module expect_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push,
  input  sram_test_pkg::sram_data_t push_data,
  input  logic                      pop,
  output sram_test_pkg::sram_data_t pop_data,
  output logic                      empty,
  output logic                      almost_full
);

  import sram_test_pkg::*;

  localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;
  localparam logic [FIFO_DEPTH_LOG2:0] FULL_COUNT = (FIFO_DEPTH_LOG2 + 1)'(DEPTH);

  sram_data_t                 mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;
  logic                       full;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign pop_data    = mem[rd_ptr];
  assign empty       = (count == '0);
  assign full        = (count == FULL_COUNT);
  // one slot of slack for the request already in flight
  assign almost_full = (count >= FULL_COUNT - 1'b1);

  assert property (@(posedge clk) disable iff (reset) !(push && full))
    else $error("expect_fifo: push while full");

  assert property (@(posedge clk) disable iff (reset) !(pop && empty))
    else $error("expect_fifo: pop while empty");

endmodule

// ==== logic/pattern_gen.sv ====
`timescale 1ns/1ps

module pattern_gen (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      clear,
  input  logic                      next,
  input  sram_test_pkg::sram_data_t seed,
  input  sram_test_pkg::sram_addr_t addr,
  output sram_test_pkg::pattern_t   pattern,
  output sram_test_pkg::sram_data_t data,
  output logic                      final_pat
);

  import sram_test_pkg::*;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      pattern <= PAT_ZEROS;
    end else if (next) begin
      case (pattern)
        PAT_ZEROS:       pattern <= PAT_ONES;
        PAT_ONES:        pattern <= PAT_CHECKER;
        PAT_CHECKER:     pattern <= PAT_INV_CHECKER;
        PAT_INV_CHECKER: pattern <= PAT_ADDR;
        default:         pattern <= PAT_ZEROS;
      endcase
    end
  end

  always_comb begin
    case (pattern)
      PAT_ZEROS:       data = '0;
      PAT_ONES:        data = '1;
      PAT_CHECKER:     data = {(DATA_BITS / 2){2'b01}};
      PAT_INV_CHECKER: data = {(DATA_BITS / 2){2'b10}};
      // address zero-extended to the word width
      default:         data = seed ^ sram_data_t'(addr);
    endcase
  end

  assign final_pat = (pattern == PAT_ADDR);

  // the tester restarts from zeros with clear, never by stepping past the end
  assert property (@(posedge clk) disable iff (reset) !(next && final_pat))
    else $error("pattern_gen: next while on final pattern");

endmodule

// ==== logic/addr_iter.sv ====
`timescale 1ns/1ps

module addr_iter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      clear,
  input  logic                      inc,
  input  sram_test_pkg::sram_addr_t last_addr,
  output sram_test_pkg::sram_addr_t addr,
  output logic                      last
);

  assign last = (addr == last_addr);

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      addr <= '0;
    end else if (inc) begin
      // wrap back to zero once the last address was used
      if (last) begin
        addr <= '0;
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

endmodule

// ==== logic/test_config.sv ====
`timescale 1ns/1ps

module test_config (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cfg_load,
  input  sram_test_pkg::test_cfg_t  cfg_in,
  output sram_test_pkg::test_cfg_t  cfg,
  output logic                      restart
);

  import sram_test_pkg::*;

  // full address range, plain address pattern
  localparam test_cfg_t CFG_RESET = '{last_addr: '1, seed: '0};

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg     <= CFG_RESET;
      restart <= 1'b0;
    end else begin
      // restart lines up with the new cfg value
      restart <= cfg_load;
      if (cfg_load) begin
        cfg <= cfg_in;
      end
    end
  end

endmodule

// ==== logic/sram_test_pkg.sv ====
package sram_test_pkg;

  localparam int ADDR_BITS = 10;
  localparam int DATA_BITS = 16;

  typedef logic [ADDR_BITS-1:0] sram_addr_t;
  typedef logic [DATA_BITS-1:0] sram_data_t;

  // data patterns in the order the tester walks them
  typedef enum logic [2:0] {
    PAT_ZEROS,
    PAT_ONES,
    PAT_CHECKER,
    PAT_INV_CHECKER,
    PAT_ADDR
  } pattern_t;

  typedef struct packed {
    sram_addr_t last_addr;
    sram_data_t seed;
  } test_cfg_t;

  typedef struct packed {
    sram_addr_t addr;
    sram_data_t data;
  } wr_req_t;

  // active low strobes, as seen on the SRAM pins
  typedef struct packed {
    sram_addr_t addr;
    logic       we_n;
    logic       oe_n;
    logic       ce_n;
  } sram_pins_t;

  typedef struct packed {
    logic       done;
    logic       pass;
    sram_addr_t fail_addr;
    pattern_t   fail_pattern;
  } test_status_t;

endpackage
